//--- dv/pepTbTasks.svh
// --------------------------------------
// Reference model of A, X and NZVC and
// the directed instruction tests
// --------------------------------------
`ifndef PEP_TB_TASKS_SVH
`define PEP_TB_TASKS_SVH

    localparam logic [7:0] SelX = 8'h08;   // r bit of a non-unary specifier

    logic [15:0] refPc     = '0;
    logic [15:0] loadPtr   = '0;   // Next free program byte
    logic [7:0]  refA      = '0;
    logic [7:0]  refX      = '0;
    logic [7:0]  refResult = '0;
    logic [3:0]  refFlags  = '0;   // N Z V C
    logic [7:0]  progSpec [$];
    logic [7:0]  progOpnd [$];

    function automatic int toSigned(input logic [7:0] b);
        return b[7] ? int'(b) - 256 : int'(b);
    endfunction

    // Applies one instruction to the model state
    task automatic stepModel(input logic [7:0] spec, input logic [7:0] opnd);
        logic [7:0] a;
        logic [7:0] y;
        logic [7:0] grp;
        logic       r;
        logic       known;
        logic       keepReg;
        logic       v;
        logic       c;
        int         sum;
        known   = 1'b1;
        keepReg = 1'b0;
        v       = 1'b0;
        c       = 1'b0;
        if (spec >= NonUnaryBase)
        begin
            r     = spec[3];
            grp   = spec & 8'hF0;
            known = (spec[2:0] == 3'b000);   // Immediate only
        end
        else
        begin
            r   = spec[0];
            grp = spec & 8'hFE;
        end
        a = r ? refX : refA;
        y = a;
        case (grp)
            OpcLdw: y = opnd;
            OpcAdd:
            begin
                y   = a + opnd;
                c   = (int'(a) + int'(opnd)) > 255;
                sum = toSigned(a) + toSigned(opnd);
                v   = (sum > 127) || (sum < -128);
            end
            OpcSub, OpcCpw:
            begin
                y       = a - opnd;
                c       = (a >= opnd);   // Carry out means no borrow
                sum     = toSigned(a) - toSigned(opnd);
                v       = (sum > 127) || (sum < -128);
                keepReg = (grp == OpcCpw);
            end
            OpcAnd: y = a & opnd;
            OpcOr:  y = a | opnd;
            OpcNot: y = ~a;
            OpcNeg:
            begin
                y   = -a;
                sum = -toSigned(a);
                v   = (sum > 127);
            end
            OpcAsl:
            begin
                y   = a << 1;
                c   = a[7];
                sum = 2 * toSigned(a);
                v   = (sum > 127) || (sum < -128);
            end
            OpcAsr:
            begin
                y = $signed(a) >>> 1;
                c = a[0];
            end
            OpcRol:
            begin
                y = (a << 1) | (a >> 7);
                c = a[7];
            end
            OpcRor:
            begin
                y = (a >> 1) | (a << 7);
                c = a[0];
            end
            default: known = 1'b0;
        endcase
        if (known)
        begin
            if (!keepReg && r)
                refX = y;
            else if (!keepReg)
                refA = y;
            refResult = y;
            refFlags  = {y[7], y == 8'h00, v, c};
        end
        refPc = refPc + ((spec >= NonUnaryBase) ? 16'd3 : 16'd1);
    endtask

    // Middle byte gets junk that the core drops
    task automatic putInstr(input logic [7:0] spec, input logic [7:0] opnd);
        mem[loadPtr] = spec;
        if (spec >= NonUnaryBase)
        begin
            mem[loadPtr + 16'd1] = ~opnd;
            mem[loadPtr + 16'd2] = opnd;
            loadPtr = loadPtr + 16'd3;
        end
        else
            loadPtr = loadPtr + 16'd1;
        progSpec.push_back(spec);
        progOpnd.push_back(opnd);
    endtask

    task automatic runProgram(input string name);
        logic [7:0]  spec;
        logic [7:0]  opnd;
        logic [15:0] expAddr;
        int          len;
        while (progSpec.size() > 0 && !aborted)
        begin
            spec = progSpec.pop_front();
            opnd = progOpnd.pop_front();
            len  = (spec >= NonUnaryBase) ? 3 : 1;
            waitDone(100);
            if (!aborted)
            begin
                checkValue(fetchLog.size(), len,
                           $sformatf("%s spec %02h fetch count", name, spec));
                for (int k = 0; k < len && fetchLog.size() > 0; k++)
                begin
                    expAddr = refPc + k[15:0];
                    checkValue(fetchLog.pop_front(), expAddr,
                               $sformatf("%s spec %02h fetch address", name, spec));
                end
                stepModel(spec, opnd);
                checkValue(result, refResult, $sformatf("%s spec %02h result", name, spec));
                checkValue(flags, refFlags, $sformatf("%s spec %02h NZVC", name, spec));
            end
        end
        progSpec.delete();
        progOpnd.delete();
    endtask

    task automatic loadImmediates();
        putInstr(OpcLdw, 8'h00);
        putInstr(OpcLdw | SelX, 8'h80);
        putInstr(OpcLdw, 8'h7F);
        putInstr(OpcLdw | SelX, 8'h00);
        putInstr(OpcLdw, 8'h80);
        putInstr(OpcLdw | SelX, 8'h7F);
        runProgram("loads");
    endtask

    task automatic addSubCarries();
        putInstr(OpcLdw, 8'h7F);
        putInstr(OpcAdd, 8'h01);          // Signed overflow
        putInstr(OpcLdw, 8'hFF);
        putInstr(OpcAdd, 8'h01);          // Carry out and zero
        putInstr(OpcLdw, 8'h10);
        putInstr(OpcAdd, 8'h22);
        putInstr(OpcLdw | SelX, 8'h80);
        putInstr(OpcSub | SelX, 8'h01);   // -128 minus 1 overflows
        putInstr(OpcLdw | SelX, 8'h05);
        putInstr(OpcSub | SelX, 8'h01);
        putInstr(OpcLdw | SelX, 8'h01);
        putInstr(OpcSub | SelX, 8'h02);   // Borrow
        runProgram("add/sub");
    endtask

    task automatic logicAndCompare();
        putInstr(OpcLdw, 8'hF0);
        putInstr(OpcAnd, 8'h3C);
        putInstr(OpcLdw | SelX, 8'h0F);
        putInstr(OpcOr | SelX, 8'h30);
        putInstr(OpcCpw, 8'h30);
        putInstr(OpcAdd, 8'h00);   // A must still read 0x30
        putInstr(OpcCpw, 8'h40);
        putInstr(OpcAdd, 8'h00);
        runProgram("logic");
    endtask

    task automatic unaryOps();
        logic [7:0] groups [6] = '{OpcNot, OpcNeg, OpcAsl, OpcAsr, OpcRol, OpcRor};
        logic [7:0] values [3] = '{8'h80, 8'h01, 8'hC3};
        for (int g = 0; g < 6; g++)
            for (int r = 0; r < 2; r++)
                for (int i = 0; i < 3; i++)
                begin
                    putInstr(OpcLdw | (r != 0 ? SelX : 8'h00), values[i]);
                    putInstr(groups[g] | r[7:0], 8'h00);
                end
        runProgram("unary");
    endtask

    task automatic unknownSpecifiers();
        putInstr(OpcLdw, 8'h80);
        putInstr(8'h02, 8'h00);            // No such unary group
        putInstr(OpcLdw | SelX, 8'h00);
        putInstr(OpcAdd | 8'h01, 8'h22);   // ADDA in direct mode
        putInstr(OpcAdd, 8'h00);           // A still holds 0x80
        putInstr(OpcLdw, 8'h7F);
        putInstr(OpcAdd, 8'h01);
        putInstr(8'hB0, 8'h55);
        putInstr(8'h5E, 8'h00);
        putInstr(OpcLdw | SelX, 8'h42);
        runProgram("unknown");
    endtask

`endif

//--- dv/pepCpuTb.sv
// --------------------------------------
// pepCpuTb
// Testbench for the Pep/9-style core
// with an APB memory model, random wait
// states and directed instruction tests
// --------------------------------------
`default_nettype none

module pepCpuTb;
    import pepPkg::*;

    logic                 Sysclk   = 1'b0;
    logic                 resetbar = 1'b0;
    apbReqT               apbReq;
    apbRspT               apbRsp   = '0;
    logic [DataWidth-1:0] result;
    statusFlagsT          flags;
    logic                 instrDone;

    logic [DataWidth-1:0] mem [0:65535];
    logic [AddrWidth-1:0] fetchLog [$];   // Addresses of completed transfers
    logic [1:0]           waitLeft;
    int                   errorCount   = 0;
    int                   timeoutCount = 0;
    bit                   aborted      = 1'b0;

    always #10 Sysclk = ~Sysclk;

    pepCpuTop dut_i (
        .Sysclk    (Sysclk),
        .resetbar  (resetbar),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .result    (result),
        .flags     (flags),
        .instrDone (instrDone)
    );

    // APB slave with 0 to 3 wait states per transfer
    initial
    begin
        int waits;
        void'($urandom(60457));
        forever
        begin
            @(posedge Sysclk);
            if (!resetbar)
            begin
                apbRsp   <= '0;
                waitLeft <= '0;
            end
            else if (apbReq.psel && !apbReq.penable)
            begin
                waits = $urandom % 4;
                waitLeft      <= waits[1:0];
                apbRsp.pready <= (waits == 0);
                apbRsp.prdata <= mem[apbReq.paddr];
            end
            else if (apbReq.psel && apbReq.penable)
            begin
                if (apbRsp.pready)
                begin
                    fetchLog.push_back(apbReq.paddr);   // Transfer ends on this edge
                    apbRsp.pready <= 1'b0;
                end
                else if (waitLeft <= 2'd1)
                    apbRsp.pready <= 1'b1;
                else
                    waitLeft <= waitLeft - 2'd1;
            end
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAIL at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    // Waits for the next instrDone pulse at the falling edges
    task automatic waitDone(input int limit);
        int cycles;
        cycles = 0;
        @(negedge Sysclk);
        while (!instrDone && cycles < limit)
        begin
            @(negedge Sysclk);
            cycles++;
        end
        if (!instrDone)
        begin
            timeoutCount++;
            aborted = 1'b1;
            $display("ERROR at %0t: no instruction completed within %0d cycles",
                     $time, limit);
        end
    endtask

`include "pepTbTasks.svh"

    initial
    begin
        int fillAddr;
        for (fillAddr = 0; fillAddr < 65536; fillAddr++)
            mem[fillAddr] = fillAddr[15:8] ^ fillAddr[7:0];

        repeat (10) @(posedge Sysclk);
        resetbar <= 1'b1;
        @(negedge Sysclk);   // Programs go in before the first setup phase

        loadImmediates();
        if (!aborted)
            addSubCarries();
        if (!aborted)
            logicAndCompare();
        if (!aborted)
            unaryOps();
        if (!aborted)
            unknownSpecifiers();

        $display("Errors: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+dv
logic/pepPkg.sv
logic/pepAlu.sv
logic/pepDecoder.sv
logic/pepApbFetch.sv
logic/pepSequencer.sv
logic/pepExecStore.sv
logic/pepCpuTop.sv
dv/pepCpuTb.sv

//--- logic/pepAlu.sv
// --------------------------------------
// pepAlu
// 8-bit ALU, result byte and new NZVC
// --------------------------------------
`default_nettype none

module pepAlu
(
    input  pepPkg::aluOpT                op,
    input  logic [pepPkg::DataWidth-1:0] a,
    input  logic [pepPkg::DataWidth-1:0] b,
    output logic [pepPkg::DataWidth-1:0] y,
    output pepPkg::statusFlagsT          flagsOut
);
    import pepPkg::*;

    logic [DataWidth:0] sum;    // Extra bit holds the carry out
    logic               v;
    logic               c;

    always_comb
    begin
        sum = '0;
        y   = a;
        v   = 1'b0;
        c   = 1'b0;
        case (op)
            AluPass:
                y = b;
            AluAdd:
            begin
                sum = {1'b0, a} + {1'b0, b};
                y   = sum[DataWidth-1:0];
                c   = sum[DataWidth];
                v   = (a[7] == b[7]) && (y[7] != a[7]);
            end
            AluSub:
            begin
                // Two's complement subtract, C is carry out, not borrow
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                y   = sum[DataWidth-1:0];
                c   = sum[DataWidth];
                v   = (a[7] != b[7]) && (y[7] != a[7]);
            end
            AluAnd:
                y = a & b;
            AluOr:
                y = a | b;
            AluNot:
                y = ~a;
            AluNeg:
            begin
                y = 8'd0 - a;
                v = (a == 8'h80);   // -128 has no positive twin
            end
            AluAsl:
            begin
                y = {a[6:0], 1'b0};
                c = a[7];
                v = a[7] ^ y[7];
            end
            AluAsr:
            begin
                y = {a[7], a[7:1]};   // Sign bit kept
                c = a[0];
            end
            AluRol:
            begin
                y = {a[6:0], a[7]};
                c = a[7];
            end
            AluRor:
            begin
                y = {a[0], a[7:1]};
                c = a[0];
            end
            default:
                y = a;
        endcase
    end

    assign flagsOut.n = y[7];
    assign flagsOut.z = (y == '0);
    assign flagsOut.v = v;
    assign flagsOut.c = c;

endmodule

`default_nettype wire

//--- logic/pepApbFetch.sv
// --------------------------------------
// pepApbFetch
// APB read master, one instruction byte
// per fetch request
// --------------------------------------
`default_nettype none

module pepApbFetch
(
    input  logic                         Sysclk,
    input  logic                         resetbar,
    input  logic                         fetchStart,
    input  logic [pepPkg::AddrWidth-1:0] fetchAddr,
    output logic                         byteValid,
    output logic [pepPkg::DataWidth-1:0] fetchByte,
    output pepPkg::apbReqT               apbReq,
    input  pepPkg::apbRspT               apbRsp
);
    import pepPkg::*;

    typedef enum logic [1:0] {ApbIdle, ApbSetup, ApbAccess} apbStateT;

    apbStateT             state;
    logic [AddrWidth-1:0] addr;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            state <= ApbIdle;
        else
            case (state)
                ApbIdle:   if (fetchStart) state <= ApbSetup;
                ApbSetup:  state <= ApbAccess;
                ApbAccess: if (apbRsp.pready) state <= ApbIdle;  // Wait states hold here
                default:   state <= ApbIdle;
            endcase
    end

    always_ff @(posedge Sysclk)
    begin
        if (state == ApbIdle && fetchStart)
            addr <= fetchAddr;
    end

    assign apbReq.paddr   = addr;
    assign apbReq.psel    = (state != ApbIdle);
    assign apbReq.penable = (state == ApbAccess);

    // Transfer ends on the edge where penable and pready are both high
    assign byteValid = (state == ApbAccess) && apbRsp.pready;
    assign fetchByte = apbRsp.prdata;

endmodule

`default_nettype wire

//--- logic/pepCpuTop.sv
// --------------------------------------
// pepCpuTop
// Pep/9-style core: sequencer, APB
// instruction fetch, decoder and the
// execute/store datapath
// --------------------------------------
`default_nettype none

module pepCpuTop
(
    input  logic                         Sysclk,
    input  logic                         resetbar,
    output pepPkg::apbReqT               apbReq,
    input  pepPkg::apbRspT               apbRsp,
    output logic [pepPkg::DataWidth-1:0] result,
    output pepPkg::statusFlagsT          flags,
    output logic                         instrDone
);
    import pepPkg::*;

    logic                 fetchStart;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 byteValid;
    logic [DataWidth-1:0] fetchByte;
    logic [DataWidth-1:0] specifier;
    logic [DataWidth-1:0] operand;
    decodedOpT            decoded;
    logic                 execEn;
    logic                 storeEn;

    pepSequencer seq_i (
        .Sysclk     (Sysclk),
        .resetbar   (resetbar),
        .fetchStart (fetchStart),
        .fetchAddr  (fetchAddr),
        .byteValid  (byteValid),
        .fetchByte  (fetchByte),
        .specifier  (specifier),
        .operand    (operand),
        .decoded    (decoded),
        .execEn     (execEn),
        .storeEn    (storeEn),
        .instrDone  (instrDone)
    );

    pepApbFetch fetch_i (
        .Sysclk     (Sysclk),
        .resetbar   (resetbar),
        .fetchStart (fetchStart),
        .fetchAddr  (fetchAddr),
        .byteValid  (byteValid),
        .fetchByte  (fetchByte),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp)
    );

    pepDecoder dec_i (
        .specifier (specifier),
        .decoded   (decoded)
    );

    pepExecStore exec_i (
        .Sysclk   (Sysclk),
        .resetbar (resetbar),
        .execEn   (execEn),
        .storeEn  (storeEn),
        .decoded  (decoded),
        .operand  (operand),
        .result   (result),
        .flags    (flags)
    );

endmodule

`default_nettype wire

//--- logic/pepDecoder.sv
// --------------------------------------
// pepDecoder
// Specifier to ALU operation, register
// select, write/flag enables and length
// --------------------------------------
`default_nettype none

module pepDecoder
(
    input  logic [pepPkg::DataWidth-1:0] specifier,
    output pepPkg::decodedOpT            decoded
);
    import pepPkg::*;

    logic [DataWidth-1:0] unaryGroup;
    logic [DataWidth-1:0] nonUnaryGroup;
    logic                 isImmediate;
    logic                 known;
    logic                 isCompare;

    assign unaryGroup    = {specifier[7:1], 1'b0};
    assign nonUnaryGroup = {specifier[7:4], 4'b0000};
    assign isImmediate   = (specifier[2:0] == 3'b000);

    always_comb
    begin
        known     = 1'b1;
        isCompare = 1'b0;
        decoded   = '0;
        decoded.aluOp    = AluPass;
        decoded.nonUnary = (specifier >= NonUnaryBase);

        if (decoded.nonUnary)
        begin
            decoded.regSel = specifier[3];
            case (nonUnaryGroup)
                OpcAdd: decoded.aluOp = AluAdd;
                OpcSub: decoded.aluOp = AluSub;
                OpcAnd: decoded.aluOp = AluAnd;
                OpcOr:  decoded.aluOp = AluOr;
                OpcLdw: decoded.aluOp = AluPass;
                OpcCpw:
                begin
                    decoded.aluOp = AluSub;
                    isCompare     = 1'b1;   // Flags only, register kept
                end
                default: known = 1'b0;
            endcase
            if (!isImmediate)
                known = 1'b0;   // Only immediate mode is supported
        end
        else
        begin
            decoded.regSel = specifier[0];
            case (unaryGroup)
                OpcNot:  decoded.aluOp = AluNot;
                OpcNeg:  decoded.aluOp = AluNeg;
                OpcAsl:  decoded.aluOp = AluAsl;
                OpcAsr:  decoded.aluOp = AluAsr;
                OpcRol:  decoded.aluOp = AluRol;
                OpcRor:  decoded.aluOp = AluRor;
                default: known = 1'b0;
            endcase
        end

        // Unknown specifiers still complete but change nothing
        decoded.writesReg = known && !isCompare;
        decoded.setsFlags = known;
    end

endmodule

`default_nettype wire

//--- logic/pepExecStore.sv
// --------------------------------------
// pepExecStore
// A and X, status flags, ALU capture in
// execute and write back in store
// --------------------------------------
`default_nettype none

module pepExecStore
(
    input  logic                         Sysclk,
    input  logic                         resetbar,
    input  logic                         execEn,
    input  logic                         storeEn,
    input  pepPkg::decodedOpT            decoded,
    input  logic [pepPkg::DataWidth-1:0] operand,
    output logic [pepPkg::DataWidth-1:0] result,
    output pepPkg::statusFlagsT          flags
);
    import pepPkg::*;

    logic [DataWidth-1:0] regA;
    logic [DataWidth-1:0] regX;
    logic [DataWidth-1:0] aluIn;
    logic [DataWidth-1:0] aluY;
    statusFlagsT          aluFlags;
    logic [DataWidth-1:0] yHold;      // ALU output held from execute to store
    statusFlagsT          flagsHold;

    assign aluIn = decoded.regSel ? regX : regA;

    pepAlu alu_i (
        .op       (decoded.aluOp),
        .a        (aluIn),
        .b        (operand),
        .y        (aluY),
        .flagsOut (aluFlags)
    );

    always_ff @(posedge Sysclk)
    begin
        if (execEn)
        begin
            yHold     <= aluY;
            flagsHold <= aluFlags;
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            regA   <= '0;
            regX   <= '0;
            result <= '0;
            flags  <= '0;
        end
        else if (storeEn)
        begin
            if (decoded.writesReg && decoded.regSel)
                regX <= yHold;
            if (decoded.writesReg && !decoded.regSel)
                regA <= yHold;
            if (decoded.setsFlags)
            begin
                flags  <= flagsHold;
                result <= yHold;   // CPW reports its difference here
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pepPkg.sv
// --------------------------------------
// pepPkg
// Shared widths, specifier constants,
// ALU operation codes and bus structs
// for the Pep/9-style core
// --------------------------------------
`default_nettype none

package pepPkg;

    localparam int DataWidth = 8;
    localparam int AddrWidth = 16;

    // Specifiers at or above this are three bytes long
    localparam logic [DataWidth-1:0] NonUnaryBase = 8'h60;

    // Unary groups, bit 0 selects A or X
    localparam logic [DataWidth-1:0] OpcNot = 8'h18;
    localparam logic [DataWidth-1:0] OpcNeg = 8'h1A;
    localparam logic [DataWidth-1:0] OpcAsl = 8'h1C;
    localparam logic [DataWidth-1:0] OpcAsr = 8'h1E;
    localparam logic [DataWidth-1:0] OpcRol = 8'h20;
    localparam logic [DataWidth-1:0] OpcRor = 8'h22;

    // Non-unary groups, bit 3 is r, bits 2:0 the addressing mode
    localparam logic [DataWidth-1:0] OpcAdd = 8'h60;
    localparam logic [DataWidth-1:0] OpcSub = 8'h70;
    localparam logic [DataWidth-1:0] OpcAnd = 8'h80;
    localparam logic [DataWidth-1:0] OpcOr  = 8'h90;
    localparam logic [DataWidth-1:0] OpcCpw = 8'hA0;
    localparam logic [DataWidth-1:0] OpcLdw = 8'hC0;

    typedef enum logic [3:0] {
        AluPass,    // Operand straight through, used by LDW
        AluAdd,
        AluSub,     // Also CPW
        AluAnd,
        AluOr,
        AluNot,
        AluNeg,
        AluAsl,
        AluAsr,
        AluRol,
        AluRor
    } aluOpT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } statusFlagsT;

    typedef struct packed {
        aluOpT aluOp;
        logic  regSel;     // 0 = A, 1 = X
        logic  writesReg;
        logic  setsFlags;
        logic  nonUnary;
    } decodedOpT;

    typedef struct packed {
        logic [AddrWidth-1:0] paddr;
        logic                 psel;
        logic                 penable;
    } apbReqT;

    typedef struct packed {
        logic [DataWidth-1:0] prdata;
        logic                 pready;
    } apbRspT;

endpackage

`default_nettype wire

//--- logic/pepSequencer.sv
// --------------------------------------
// pepSequencer
// Fetch, decode, execute and store
// phases, program counter and capture
// of the specifier and operand bytes
// --------------------------------------
`default_nettype none

module pepSequencer
(
    input  logic                         Sysclk,
    input  logic                         resetbar,
    output logic                         fetchStart,
    output logic [pepPkg::AddrWidth-1:0] fetchAddr,
    input  logic                         byteValid,
    input  logic [pepPkg::DataWidth-1:0] fetchByte,
    output logic [pepPkg::DataWidth-1:0] specifier,
    output logic [pepPkg::DataWidth-1:0] operand,
    input  pepPkg::decodedOpT            decoded,
    output logic                         execEn,
    output logic                         storeEn,
    output logic                         instrDone
);
    import pepPkg::*;

    typedef enum logic [2:0] {
        SeqBoot,    // One cycle after reset to launch the first fetch
        SeqFetch,
        SeqDecode,
        SeqExecute,
        SeqStore
    } seqStateT;

    seqStateT             state;
    logic [AddrWidth-1:0] pc;
    logic [1:0]           byteCnt;   // Bytes received for this instruction

    assign fetchAddr = pc;
    assign execEn    = (state == SeqExecute);
    assign storeEn   = (state == SeqStore);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state      <= SeqBoot;
            pc         <= '0;
            byteCnt    <= '0;
            fetchStart <= 1'b0;
            instrDone  <= 1'b0;
        end
        else
        begin
            fetchStart <= 1'b0;
            instrDone  <= 1'b0;
            case (state)
                SeqBoot:
                begin
                    fetchStart <= 1'b1;
                    state      <= SeqFetch;
                end
                SeqFetch:
                    if (byteValid)
                    begin
                        pc      <= pc + 1'b1;   // Wraps at 16 bits
                        byteCnt <= byteCnt + 1'b1;
                        if (byteCnt == 2'd1)
                            fetchStart <= 1'b1; // Middle byte dropped, fetch operand
                        else
                            state <= SeqDecode;
                    end
                SeqDecode:
                    // Length is known only once the specifier sits in its register
                    if (decoded.nonUnary && byteCnt == 2'd1)
                    begin
                        fetchStart <= 1'b1;
                        state      <= SeqFetch;
                    end
                    else
                    begin
                        state <= SeqExecute;
                    end
                SeqExecute:
                    state <= SeqStore;
                SeqStore:
                begin
                    byteCnt    <= '0;
                    instrDone  <= 1'b1;
                    fetchStart <= 1'b1;   // Next instruction starts with the done pulse
                    state      <= SeqFetch;
                end
                default:
                    state <= SeqBoot;
            endcase
        end
    end

    // Byte 0 is the specifier, byte 2 the immediate operand
    always_ff @(posedge Sysclk)
    begin
        if (state == SeqFetch && byteValid)
        begin
            if (byteCnt == 2'd0)
                specifier <= fetchByte;
            if (byteCnt == 2'd2)
                operand <= fetchByte;
        end
    end

endmodule

`default_nettype wire
